//--- mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// bus and datapath widths
`define MEM_AW              32
`define MEM_DW              32

// instruction cache geometry, 256 lines of 4 words gives 4 kB
`define MEM_LINE_WORDS      4
`define MEM_LINES           256

// request credits per client, also the queue depth
`define MEM_CREDITS         2

// fetches below this byte address bypass the cache (lowest 8 kB)
`define MEM_UNCACHED_TOP    32'h0000_2000

// bus cycle-type codes
`define MEM_CTI_CLASSIC     3'b000
`define MEM_CTI_INCR        3'b010
`define MEM_CTI_END         3'b111

`endif

//--- mem_pkg.sv
`default_nettype none
`include "mem_macros.svh"

package mem_pkg;

	// --------------------------------------------------
	// client request and response channels
	// --------------------------------------------------
	typedef struct packed {
		logic [`MEM_AW-1:0] adr;	// byte address of the instruction word
	} fetch_req_t;

	typedef struct packed {
		logic [`MEM_DW-1:0] insn;
	} fetch_rsp_t;

	typedef struct packed {
		logic [`MEM_AW-1:0] adr;
		logic               we;
		logic               byte_sz;	// 1 = byte access, 0 = word
		logic [`MEM_DW-1:0] wdat;
	} data_req_t;

	typedef struct packed {
		logic [`MEM_DW-1:0] rdat;	// zero for writes
	} data_rsp_t;

	// --------------------------------------------------
	// client to arbiter
	// --------------------------------------------------
	typedef struct packed {
		logic [`MEM_AW-1:0] adr;
		logic               we;
		logic [3:0]         sel;	// byte lanes
		logic [`MEM_DW-1:0] dat;
		logic [2:0]         cti;
	} bus_req_t;

	typedef struct packed {
		logic               ack;
		logic [`MEM_DW-1:0] dat;
	} bus_rsp_t;

endpackage

`default_nettype wire

//--- req_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module req_fifo #(
	parameter type payload_t = mem_pkg::fetch_req_t
) (
	input  wire           clk,
	input  wire           rst_i,
	input  wire           push_i,
	input  wire payload_t push_data_i,
	input  wire           pop_i,
	output logic          valid_o,
	output payload_t      data_o,
	output logic          credit_o
);
	// depth equals the credit count, so a push never finds the queue full
	logic [$clog2(`MEM_CREDITS)-1:0]   wr_ptr;
	logic [$clog2(`MEM_CREDITS)-1:0]   rd_ptr;
	logic [$clog2(`MEM_CREDITS+1)-1:0] count;
	payload_t                          slots [`MEM_CREDITS];

	wire do_pop = pop_i && valid_o;

	assign valid_o  = count != '0;
	assign data_o   = slots[rd_ptr];
	assign credit_o = do_pop;	// one credit back per request leaving

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= (wr_ptr == $bits(wr_ptr)'(`MEM_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == $bits(rd_ptr)'(`MEM_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			if (push_i && !do_pop)
				count <= count + 1'b1;
			else if (!push_i && do_pop)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push_i)
			slots[wr_ptr] <= push_data_i;
	end

endmodule

`default_nettype wire

//--- icache_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module icache_unit (
	input  wire                      clk,
	input  wire                      rst_i,
	input  wire                      req_valid_i,
	input  wire mem_pkg::fetch_req_t req_i,
	output logic                     pop_o,
	output logic                     rsp_valid_o,
	output mem_pkg::fetch_rsp_t      rsp_o,
	output logic                     bus_req_o,
	output mem_pkg::bus_req_t        bus_o,
	input  wire                      grant_i,
	input  wire mem_pkg::bus_rsp_t   bus_rsp_i
);
	import mem_pkg::*;

	localparam int WRD_W = $clog2(`MEM_LINE_WORDS);
	localparam int OFF_W = WRD_W + 2;	// word in line plus byte in word
	localparam int IDX_W = $clog2(`MEM_LINES);
	localparam int TAG_W = `MEM_AW - OFF_W - IDX_W;

	typedef enum logic [1:0] {S_SWEEP, S_IDLE, S_REFILL, S_UNCACHED} state_e;

	state_e             state;
	fetch_req_t         cur_req;	// fetch being served
	logic [IDX_W-1:0]   sweep_idx;
	logic [WRD_W-1:0]   beat;
	logic [TAG_W-1:0]   tag_mem [`MEM_LINES];
	logic               tag_vld [`MEM_LINES];
	logic [`MEM_DW-1:0] line_mem [`MEM_LINES*`MEM_LINE_WORDS];

	// lookup on the queue head
	wire [IDX_W-1:0] req_idx      = req_i.adr[OFF_W +: IDX_W];
	wire [WRD_W-1:0] req_wrd      = req_i.adr[2 +: WRD_W];
	wire [TAG_W-1:0] req_tag      = req_i.adr[`MEM_AW-1 -: TAG_W];
	wire             req_uncached = req_i.adr < `MEM_UNCACHED_TOP;
	wire             req_hit      = tag_vld[req_idx] && tag_mem[req_idx] == req_tag;

	wire [IDX_W-1:0] cur_idx   = cur_req.adr[OFF_W +: IDX_W];
	wire [WRD_W-1:0] cur_wrd   = cur_req.adr[2 +: WRD_W];
	wire [TAG_W-1:0] cur_tag   = cur_req.adr[`MEM_AW-1 -: TAG_W];
	wire             beat_ack  = grant_i && bus_rsp_i.ack;
	wire             last_beat = beat == WRD_W'(`MEM_LINE_WORDS - 1);

	assign pop_o     = state == S_IDLE && req_valid_i;
	assign bus_req_o = state == S_REFILL || state == S_UNCACHED;

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state       <= S_SWEEP;
			sweep_idx   <= '0;
			beat        <= '0;
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= 1'b0;
			case (state)
			S_SWEEP: begin	// one line per cycle
				sweep_idx <= sweep_idx + 1'b1;
				if (sweep_idx == IDX_W'(`MEM_LINES - 1))
					state <= S_IDLE;
			end
			S_IDLE: if (req_valid_i) begin
				if (req_uncached)
					state <= S_UNCACHED;
				else if (req_hit)
					rsp_valid_o <= 1'b1;
				else begin
					state <= S_REFILL;
					beat  <= '0;
				end
			end
			S_REFILL: if (beat_ack) begin
				beat <= beat + 1'b1;
				if (last_beat) begin
					state       <= S_IDLE;
					rsp_valid_o <= 1'b1;
				end
			end
			S_UNCACHED: if (beat_ack) begin
				state       <= S_IDLE;
				rsp_valid_o <= 1'b1;
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// tag and data arrays
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == S_SWEEP)
			tag_vld[sweep_idx] <= 1'b0;
		if (pop_o)
			cur_req <= req_i;
		if (pop_o && !req_uncached && req_hit)
			rsp_o.insn <= line_mem[{req_idx, req_wrd}];
		if (state == S_REFILL && beat_ack) begin
			line_mem[{cur_idx, beat}] <= bus_rsp_i.dat;
			if (beat == cur_wrd)
				rsp_o.insn <= bus_rsp_i.dat;	// critical word
			if (last_beat) begin
				tag_mem[cur_idx] <= cur_tag;
				tag_vld[cur_idx] <= 1'b1;
			end
		end
		if (state == S_UNCACHED && beat_ack)
			rsp_o.insn <= bus_rsp_i.dat;
	end

	always_comb begin
		bus_o     = '0;
		bus_o.sel = 4'hf;
		if (state == S_REFILL) begin	// burst walks the line from word 0
			bus_o.adr = {cur_req.adr[`MEM_AW-1:OFF_W], beat, 2'b00};
			bus_o.cti = last_beat ? `MEM_CTI_END : `MEM_CTI_INCR;
		end else begin
			bus_o.adr = {cur_req.adr[`MEM_AW-1:2], 2'b00};
			bus_o.cti = `MEM_CTI_CLASSIC;
		end
	end

endmodule

`default_nettype wire

//--- data_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module data_port (
	input  wire                     clk,
	input  wire                     rst_i,
	input  wire                     req_valid_i,
	input  wire mem_pkg::data_req_t req_i,
	output logic                    pop_o,
	output logic                    rsp_valid_o,
	output mem_pkg::data_rsp_t      rsp_o,
	output logic                    bus_req_o,
	output mem_pkg::bus_req_t       bus_o,
	input  wire                     grant_i,
	input  wire mem_pkg::bus_rsp_t  bus_rsp_i
);
	import mem_pkg::*;

	typedef enum logic [0:0] {S_IDLE, S_BUS} state_e;

	state_e     state;
	data_req_t  cur_req;
	logic [7:0] rd_byte;

	wire [1:0] lane     = cur_req.adr[1:0];
	wire       beat_ack = grant_i && bus_rsp_i.ack;

	assign pop_o     = state == S_IDLE && req_valid_i;
	assign bus_req_o = state == S_BUS;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state       <= S_IDLE;
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= 1'b0;
			case (state)
			S_IDLE: if (req_valid_i)
				state <= S_BUS;
			S_BUS: if (beat_ack) begin
				state       <= S_IDLE;
				rsp_valid_o <= 1'b1;
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop_o)
			cur_req <= req_i;
		if (state == S_BUS && beat_ack) begin
			if (cur_req.we)
				rsp_o.rdat <= '0;
			else if (cur_req.byte_sz)
				rsp_o.rdat <= {{(`MEM_DW-8){1'b0}}, rd_byte};	// zero-extend
			else
				rsp_o.rdat <= bus_rsp_i.dat;
		end
	end

	// lane pick for byte reads
	always_comb begin
		case (lane)
		2'd0:    rd_byte = bus_rsp_i.dat[7:0];
		2'd1:    rd_byte = bus_rsp_i.dat[15:8];
		2'd2:    rd_byte = bus_rsp_i.dat[23:16];
		default: rd_byte = bus_rsp_i.dat[31:24];
		endcase
	end

	always_comb begin
		bus_o.adr = {cur_req.adr[`MEM_AW-1:2], 2'b00};
		bus_o.we  = cur_req.we;
		bus_o.cti = `MEM_CTI_CLASSIC;
		if (cur_req.byte_sz) begin
			bus_o.sel = 4'b0001 << lane;
			bus_o.dat = {(`MEM_DW/8){cur_req.wdat[7:0]}};	// byte on every lane
		end else begin
			bus_o.sel = 4'hf;
			bus_o.dat = cur_req.wdat;
		end
	end

endmodule

`default_nettype wire

//--- bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module bus_arbiter (
	input  wire                    clk,
	input  wire                    rst_i,
	input  wire                    ic_req_i,
	input  wire mem_pkg::bus_req_t ic_bus_i,
	output logic                   ic_grant_o,
	output mem_pkg::bus_rsp_t      ic_rsp_o,
	input  wire                    dp_req_i,
	input  wire mem_pkg::bus_req_t dp_bus_i,
	output logic                   dp_grant_o,
	output mem_pkg::bus_rsp_t      dp_rsp_o,
	output logic                   cyc_o,
	output logic                   stb_o,
	output logic                   we_o,
	output logic [3:0]             sel_o,
	output logic [`MEM_AW-1:0]     adr_o,
	output logic [`MEM_DW-1:0]     dat_o,
	output logic [2:0]             cti_o,
	input  wire                    ack_i,
	input  wire  [`MEM_DW-1:0]     dat_i
);
	import mem_pkg::*;

	typedef enum logic [1:0] {OWN_NONE, OWN_IC, OWN_DP} owner_e;

	owner_e   owner;
	bus_req_t cur;	// request of the current owner

	// a classic cycle ends on its ack, a burst on the ack of its last beat
	wire closing = ack_i && (cur.cti == `MEM_CTI_CLASSIC || cur.cti == `MEM_CTI_END);

	always_ff @(posedge clk) begin
		if (rst_i)
			owner <= OWN_NONE;
		else begin
			case (owner)
			OWN_NONE: begin
				if (dp_req_i)
					owner <= OWN_DP;	// data side first
				else if (ic_req_i)
					owner <= OWN_IC;
			end
			default: if (closing)
				owner <= OWN_NONE;
			endcase
		end
	end

	always_comb begin
		case (owner)
		OWN_IC:  cur = ic_bus_i;
		OWN_DP:  cur = dp_bus_i;
		default: cur = '0;
		endcase
	end

	// --------------------------------------------------
	// bus master outputs
	// --------------------------------------------------
	assign cyc_o = owner != OWN_NONE;
	assign stb_o = cyc_o;
	assign we_o  = cur.we;
	assign sel_o = cur.sel;
	assign adr_o = cur.adr;
	assign dat_o = cur.dat;
	assign cti_o = cur.cti;

	assign ic_grant_o = owner == OWN_IC;
	assign dp_grant_o = owner == OWN_DP;

	always_comb begin	// only the owner sees ack and data
		ic_rsp_o.ack = ack_i && ic_grant_o;
		ic_rsp_o.dat = ic_grant_o ? dat_i : '0;
		dp_rsp_o.ack = ack_i && dp_grant_o;
		dp_rsp_o.dat = dp_grant_o ? dat_i : '0;
	end

endmodule

`default_nettype wire

//--- mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module mem_top (
	input  wire                      clk,
	input  wire                      rst_i,
	input  wire                      fetch_valid_i,
	input  wire mem_pkg::fetch_req_t fetch_i,
	output logic                     fetch_credit_o,
	output logic                     fetch_rsp_valid_o,
	output mem_pkg::fetch_rsp_t      fetch_rsp_o,
	input  wire                      data_valid_i,
	input  wire mem_pkg::data_req_t  data_i,
	output logic                     data_credit_o,
	output logic                     data_rsp_valid_o,
	output mem_pkg::data_rsp_t       data_rsp_o,
	output logic                     cyc_o,
	output logic                     stb_o,
	output logic                     we_o,
	output logic [3:0]               sel_o,
	output logic [`MEM_AW-1:0]       adr_o,
	output logic [`MEM_DW-1:0]       dat_o,
	output logic [2:0]               cti_o,
	input  wire                      ack_i,
	input  wire  [`MEM_DW-1:0]       dat_i
);
	import mem_pkg::*;

	// --------------------------------------------------
	// request queues
	// --------------------------------------------------
	logic       fq_valid, fq_pop;
	fetch_req_t fq_data;
	logic       dq_valid, dq_pop;
	data_req_t  dq_data;

	req_fifo #(.payload_t(fetch_req_t)) i_fetch_q (
		.clk(clk), .rst_i(rst_i),
		.push_i(fetch_valid_i), .push_data_i(fetch_i),
		.pop_i(fq_pop), .valid_o(fq_valid), .data_o(fq_data),
		.credit_o(fetch_credit_o)
	);

	req_fifo #(.payload_t(data_req_t)) i_data_q (
		.clk(clk), .rst_i(rst_i),
		.push_i(data_valid_i), .push_data_i(data_i),
		.pop_i(dq_pop), .valid_o(dq_valid), .data_o(dq_data),
		.credit_o(data_credit_o)
	);

	// --------------------------------------------------
	// clients and shared bus
	// --------------------------------------------------
	logic     ic_req, ic_grant, dp_req, dp_grant;
	bus_req_t ic_bus, dp_bus;
	bus_rsp_t ic_rsp, dp_rsp;

	icache_unit i_icache (
		.clk(clk), .rst_i(rst_i),
		.req_valid_i(fq_valid), .req_i(fq_data), .pop_o(fq_pop),
		.rsp_valid_o(fetch_rsp_valid_o), .rsp_o(fetch_rsp_o),
		.bus_req_o(ic_req), .bus_o(ic_bus), .grant_i(ic_grant), .bus_rsp_i(ic_rsp)
	);

	data_port i_dport (
		.clk(clk), .rst_i(rst_i),
		.req_valid_i(dq_valid), .req_i(dq_data), .pop_o(dq_pop),
		.rsp_valid_o(data_rsp_valid_o), .rsp_o(data_rsp_o),
		.bus_req_o(dp_req), .bus_o(dp_bus), .grant_i(dp_grant), .bus_rsp_i(dp_rsp)
	);

	bus_arbiter i_arb (
		.clk(clk), .rst_i(rst_i),
		.ic_req_i(ic_req), .ic_bus_i(ic_bus), .ic_grant_o(ic_grant), .ic_rsp_o(ic_rsp),
		.dp_req_i(dp_req), .dp_bus_i(dp_bus), .dp_grant_o(dp_grant), .dp_rsp_o(dp_rsp),
		.cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o), .sel_o(sel_o),
		.adr_o(adr_o), .dat_o(dat_o), .cti_o(cti_o),
		.ack_i(ack_i), .dat_i(dat_i)
	);

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rst_o
);
	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst_o = 1'b1;
		repeat (10) @(negedge clk);
		rst_o <= 1'b0;	// released on a falling edge
	end

endmodule

`default_nettype wire

//--- mem_assert.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module mem_assert (
	input wire                 clk,
	input wire                 rst_i,
	input wire                 ic_req_i,
	input wire                 dp_req_i,
	input wire                 ic_grant_i,
	input wire                 dp_grant_i,
	input wire                 cyc_i,
	input wire                 stb_i,
	input wire [`MEM_AW-1:0]   adr_i,
	input wire                 ack_i
);

	// one owner at a time, and only a client that still requests
	a_one_grant: assert property (@(posedge clk) disable iff (rst_i)
		!(ic_grant_i && dp_grant_i) && (!ic_grant_i || ic_req_i)
		&& (!dp_grant_i || dp_req_i))
		else $error("bus granted twice or to a client without a request");

	// wait states neither drop the cycle nor move the grant
	a_cyc_stb: assert property (@(posedge clk) disable iff (rst_i)
		(cyc_i && !ack_i) |=> (cyc_i && stb_i && $stable({ic_grant_i, dp_grant_i})))
		else $error("bus cycle or grant changed while waiting for an ack");

	// address held through wait states
	a_adr_hold: assert property (@(posedge clk) disable iff (rst_i)
		(stb_i && !ack_i) |=> $stable(adr_i))
		else $error("adr_o changed while a strobe waited for its ack");

endmodule

`default_nettype wire

//--- tb_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module tb_mem_top;
	import mem_pkg::*;

	localparam logic [31:0] XOR_K    = 32'h5a5a_c3c3;
	localparam int          WAIT_MAX = 3000;

	logic               clk;
	logic               rst;
	logic               fetch_valid;
	fetch_req_t         fetch_req;
	logic               fetch_credit;
	logic               fetch_rsp_valid;
	fetch_rsp_t         fetch_rsp;
	logic               data_valid;
	data_req_t          data_req;
	logic               data_credit;
	logic               data_rsp_valid;
	data_rsp_t          data_rsp;
	logic               cyc;
	logic               stb;
	logic               we;
	logic               ack;
	logic [3:0]         sel;
	logic [`MEM_AW-1:0] adr;
	logic [`MEM_DW-1:0] wdat;
	logic [`MEM_DW-1:0] rdat;
	logic [2:0]         cti;

	integer      seed = 32'h500a_bd28;
	int          fetch_credits = `MEM_CREDITS;
	int          data_credits = `MEM_CREDITS;
	int          fetch_sent, fetch_done, data_sent, data_done;
	int          ack_count, classic_count, wait_left;
	logic [31:0] fetch_exp [$];
	logic [31:0] data_exp [$];
	logic [31:0] bus_mem [logic [31:0]];	// bus model storage
	logic [31:0] ref_mem [logic [31:0]];	// reference model, updated in issue order

	tb_clkgen i_clkgen (.clk(clk), .rst_o(rst));

	mem_top i_dut (
		.clk(clk), .rst_i(rst),
		.fetch_valid_i(fetch_valid), .fetch_i(fetch_req), .fetch_credit_o(fetch_credit),
		.fetch_rsp_valid_o(fetch_rsp_valid), .fetch_rsp_o(fetch_rsp),
		.data_valid_i(data_valid), .data_i(data_req), .data_credit_o(data_credit),
		.data_rsp_valid_o(data_rsp_valid), .data_rsp_o(data_rsp),
		.cyc_o(cyc), .stb_o(stb), .we_o(we), .sel_o(sel), .adr_o(adr), .dat_o(wdat),
		.cti_o(cti), .ack_i(ack), .dat_i(rdat)
	);

	bind bus_arbiter mem_assert i_arb_assert (
		.clk(clk), .rst_i(rst_i), .ic_req_i(ic_req_i), .dp_req_i(dp_req_i),
		.ic_grant_i(ic_grant_o), .dp_grant_i(dp_grant_o),
		.cyc_i(cyc_o), .stb_i(stb_o), .adr_i(adr_o), .ack_i(ack_i)
	);

	// unwritten words read as their address xor a constant
	function automatic logic [31:0] default_word(input logic [31:0] a);
		return {a[31:2], 2'b00} ^ XOR_K;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic next_cycle();
		@(negedge clk);
		fetch_valid = 1'b0;	// valids last one cycle
		data_valid  = 1'b0;
	endtask

	// --------------------------------------------------
	// request senders with reference model
	// --------------------------------------------------
	task automatic send_fetch(input logic [31:0] a);
		int n;
		n = 0;
		while (fetch_credits == 0) begin
			next_cycle();
			n++;
			if (n > WAIT_MAX)
				abort_run("timeout waiting for a fetch credit");
		end
		fetch_valid   = 1'b1;
		fetch_req.adr = a;
		fetch_exp.push_back(default_word(a));	// fetch region is never written
		fetch_credits--;
		fetch_sent++;
	endtask

	task automatic send_data(input logic wr, input logic bsz, input logic [31:0] a,
		input logic [31:0] wd);
		logic [31:0] wa;
		logic [31:0] w;
		int          lane;
		int          n;
		n = 0;
		while (data_credits == 0) begin
			next_cycle();
			n++;
			if (n > WAIT_MAX)
				abort_run("timeout waiting for a data credit");
		end
		wa   = {a[31:2], 2'b00};
		lane = a[1:0];
		w    = ref_mem.exists(wa) ? ref_mem[wa] : default_word(wa);
		if (wr) begin
			if (bsz)
				w[8*lane +: 8] = wd[7:0];
			else
				w = wd;
			ref_mem[wa] = w;
			data_exp.push_back(32'h0);	// writes answer zero
		end else if (bsz)
			data_exp.push_back({24'h0, w[8*lane +: 8]});
		else
			data_exp.push_back(w);
		data_valid       = 1'b1;
		data_req.adr     = a;
		data_req.we      = wr;
		data_req.byte_sz = bsz;
		data_req.wdat    = wd;
		data_credits--;
		data_sent++;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (fetch_exp.size() != 0 || data_exp.size() != 0
			|| fetch_credits != `MEM_CREDITS || data_credits != `MEM_CREDITS) begin
			next_cycle();
			n++;
			if (n > WAIT_MAX)
				abort_run("timeout waiting for outstanding responses");
		end
	endtask

	// --------------------------------------------------
	// bus memory model, 0 to 3 wait states per beat
	// --------------------------------------------------
	always @(negedge clk) begin
		logic [31:0] wa;
		logic [31:0] w;
		int          b;
		ack = 1'b0;
		if (rst)
			wait_left = $random(seed) & 3;
		else if (stb) begin
			if (wait_left == 0) begin
				wa = {adr[31:2], 2'b00};
				w  = bus_mem.exists(wa) ? bus_mem[wa] : default_word(wa);
				if (we) begin
					for (b = 0; b < 4; b++)
						if (sel[b])
							w[8*b +: 8] = wdat[8*b +: 8];
					bus_mem[wa] = w;
				end
				rdat = we ? 32'h0 : w;
				ack  = 1'b1;
				ack_count++;
				if (cti == `MEM_CTI_CLASSIC)
					classic_count++;
				wait_left = $random(seed) & 3;
			end else
				wait_left--;
		end
	end

	// response and credit monitor
	always @(negedge clk) begin
		logic [31:0] exp;
		if (!rst) begin
			if (fetch_credit)
				fetch_credits++;
			if (data_credit)
				data_credits++;
			assert (fetch_credits <= `MEM_CREDITS && data_credits <= `MEM_CREDITS)
				else abort_run("a client got back more credits than it was given");
			if (fetch_rsp_valid) begin
				assert (fetch_exp.size() > 0)
					else abort_run("fetch response with no fetch outstanding");
				exp = fetch_exp.pop_front();
				assert (fetch_rsp.insn == exp) else report_mismatch("fetch", exp, fetch_rsp.insn);
				fetch_done++;
			end
			if (data_rsp_valid) begin
				assert (data_exp.size() > 0)
					else abort_run("data response with no data request outstanding");
				exp = data_exp.pop_front();
				assert (data_rsp.rdat == exp) else report_mismatch("data", exp, data_rsp.rdat);
				data_done++;
			end
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] r;
		int          base_acks;
		int          base_classic;
		int          n;
		fetch_valid = 1'b0;
		fetch_req   = '0;
		data_valid  = 1'b0;
		data_req    = '0;
		ack         = 1'b0;
		rdat        = '0;
		@(negedge clk);
		n = 0;
		while (rst) begin
			@(negedge clk);
			n++;
			if (n > 50)
				abort_run("reset was never released");
		end

		// sweep holds the fetch back for MEM_LINES cycles
		assert (!cyc && !fetch_rsp_valid && !data_rsp_valid)
			else abort_run("bus or response active right after reset");
		send_fetch(32'h0001_0040);
		for (int i = 0; i < `MEM_LINES; i++) begin
			next_cycle();
			assert (!cyc && !fetch_rsp_valid) else abort_run("cache served a fetch during its sweep");
		end
		wait_drain();

		// a miss refills the line with one burst, later hits stay off the bus
		a            = 32'h0001_0100;
		base_acks    = ack_count;
		base_classic = classic_count;
		send_fetch(a);
		next_cycle();
		wait_drain();
		assert (ack_count == base_acks + `MEM_LINE_WORDS)
			else report_mismatch("refill beats", base_acks + `MEM_LINE_WORDS, ack_count);
		assert (classic_count == base_classic)
			else report_mismatch("refill classic cycles", base_classic, classic_count);
		base_acks = ack_count;
		send_fetch(a + 32'd4);
		next_cycle();
		send_fetch(a);
		next_cycle();
		wait_drain();
		assert (ack_count == base_acks) else report_mismatch("hit bus cycles", base_acks, ack_count);

		// uncached region, one classic cycle every time
		for (int i = 0; i < 8; i++) begin
			if (i % 2 == 0) begin
				r = $random(seed);
				a = {19'd0, r[12:2], 2'b00};
			end
			base_acks    = ack_count;
			base_classic = classic_count;
			send_fetch(a);
			next_cycle();
			wait_drain();
			assert (ack_count == base_acks + 1)
				else report_mismatch("uncached bus cycles", base_acks + 1, ack_count);
			assert (classic_count == base_classic + 1)
				else report_mismatch("uncached classic cycles", base_classic + 1, classic_count);
		end

		// word write, byte write on lane 2, then word and byte reads
		send_data(1'b1, 1'b0, 32'h0004_0010, 32'hdead_beef);
		next_cycle();
		send_data(1'b1, 1'b1, 32'h0004_0012, 32'h0000_0077);
		next_cycle();
		send_data(1'b0, 1'b0, 32'h0004_0010, 32'h0);
		next_cycle();
		for (int i = 0; i < 4; i++) begin
			send_data(1'b0, 1'b1, 32'h0004_0010 + i, 32'h0);
			next_cycle();
		end
		wait_drain();

		// --------------------------------------------------
		// random mix on both clients
		// --------------------------------------------------
		for (int i = 0; i < 800; i++) begin
			next_cycle();
			r = $random(seed);
			if (r[0] && fetch_credits > 0) begin
				a = $random(seed);
				a = {19'd0, a[12:2], 2'b00};
				send_fetch(r[1] ? a : (a | 32'h0001_0000));	// uncached or cached
			end
			if (r[2] && data_credits > 0) begin
				a = $random(seed);
				a = 32'h0004_0000 | {26'd0, a[5:2], (r[4] ? a[1:0] : 2'b00)};
				send_data(r[3], r[4], a, $random(seed));
			end
		end
		next_cycle();
		wait_drain();

		if (fetch_done == fetch_sent && data_done == data_sent
			&& fetch_credits == `MEM_CREDITS && data_credits == `MEM_CREDITS) begin
			$display("Test OK");
			$finish;
		end else
			abort_run("responses or credits missing at the end of the run");
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
mem_pkg.sv
req_fifo.sv
icache_unit.sv
data_port.sv
bus_arbiter.sv
mem_top.sv
tb_clkgen.sv
mem_assert.sv
tb_mem_top.sv

//--- run.sh
#!/bin/sh
# compile and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mem_top -f filelist.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit $status
fi

./obj_dir/Vtb_mem_top
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
